/* source/lsu_pkg.sv */
// Shared widths, sizes, function codes and instruction views for the load/store unit
package lsu_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 8;
    localparam int TAG_WIDTH      = 4;
    localparam int MEM_WORDS      = 64;
    localparam int SQ_DEPTH       = 4;
    localparam int SQ_PTR_WIDTH   = $clog2(SQ_DEPTH);
    localparam int WORD_IDX_WIDTH = $clog2(MEM_WORDS);
    localparam int BYTE_LANES     = DATA_WIDTH / 8;

    // RISC-V major opcodes handled here
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } lsu_func_t;

    // I-type layout, used by loads
    typedef struct packed {
        logic [11:0] imm_hi;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } lsu_insn_i_t;

    // S-type layout, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } lsu_insn_s_t;

    typedef union packed {
        lsu_insn_i_t i;
        lsu_insn_s_t s;
    } lsu_insn_u;

endpackage

/* source/lsu_ifs.sv */
// Interfaces for queue requests and execute-stage ops passed between the LSU blocks
`timescale 1ns/1ps

interface lsu_req_if;
    import lsu_pkg::*;

    logic                  valid;
    lsu_func_t             func;
    logic [TAG_WIDTH-1:0]  tag;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic                  ready;

    modport src (output valid, func, tag, addr, data, input ready);
    modport dst (input valid, func, tag, addr, data, output ready);
endinterface

interface lsu_exe_if;
    import lsu_pkg::*;

    logic                  valid;
    logic                  is_store;
    lsu_func_t             func;
    logic [TAG_WIDTH-1:0]  tag;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;

    modport ad (output valid, is_store, func, tag, addr, data);
    modport dc (input valid, is_store, func, tag, addr, data);
endinterface

/* source/lsu_ad.sv */
// Decodes issued load/store ops, forms addresses and arbitrates retire vs issue into execute
`timescale 1ns/1ps

module lsu_ad (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_flush,
    input  logic                            i_valid,
    input  lsu_pkg::lsu_insn_u              i_insn,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]  i_src_a,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]  i_src_b,
    input  logic [lsu_pkg::TAG_WIDTH-1:0]   i_tag,
    input  logic                            i_sq_empty,
    output logic                            o_ready,
    lsu_req_if.src                          sq_alloc,
    lsu_req_if.dst                          sq_retire,
    lsu_exe_if.ad                           exe
);
    import lsu_pkg::*;

    logic                  is_load;
    logic                  is_store;
    logic [DATA_WIDTH-1:0] imm_i;
    logic [DATA_WIDTH-1:0] imm_s;
    logic [DATA_WIDTH-1:0] addr_sum;
    logic [ADDR_WIDTH-1:0] addr;
    lsu_func_t             lsu_func;
    logic                  accept;
    logic                  retire_fire;

    assign is_load  = i_insn.i.opcode == OPCODE_LOAD;
    assign is_store = i_insn.i.opcode == OPCODE_STORE;

    // Both immediate views are sign extended from bit 31 of the instruction
    assign imm_i = {{(DATA_WIDTH-12){i_insn.i.imm_hi[11]}}, i_insn.i.imm_hi};
    assign imm_s = {{(DATA_WIDTH-12){i_insn.s.imm_hi[6]}}, i_insn.s.imm_hi, i_insn.s.imm_lo};

    assign addr_sum = i_src_a + (is_store ? imm_s : imm_i);
    assign addr     = addr_sum[ADDR_WIDTH-1:0];

    // Unknown funct3 falls back to a word access
    always_comb begin
        case (i_insn.i.funct3)
            3'b000:  lsu_func = is_store ? SB : LB;
            3'b001:  lsu_func = is_store ? SH : LH;
            3'b100:  lsu_func = is_store ? SW : LBU;
            3'b101:  lsu_func = is_store ? SW : LHU;
            default: lsu_func = is_store ? SW : LW;
        endcase
    end

    // Stall on a full queue, a pending retire or an allocation still in flight.
    // Loads also wait until every older store has drained from the queue
    assign o_ready = sq_alloc.ready & ~sq_retire.valid & ~sq_alloc.valid
                   & ~(is_load & ~i_sq_empty);

    assign accept          = i_valid & o_ready;
    assign sq_retire.ready = ~i_flush;
    assign retire_fire     = sq_retire.valid & sq_retire.ready;

    // Store allocation, one cycle after the accept edge
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            sq_alloc.valid <= 1'b0;
        end else begin
            sq_alloc.valid <= accept & is_store & ~i_flush;
        end
    end

    always_ff @(posedge clk) begin
        sq_alloc.func <= lsu_func;
        sq_alloc.tag  <= i_tag;
        sq_alloc.addr <= addr;
        sq_alloc.data <= i_src_b;
    end

    // Execute register, retiring stores win over newly issued loads
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= retire_fire | (accept & is_load & ~i_flush);
        end
    end

    always_ff @(posedge clk) begin
        if (retire_fire) begin
            exe.is_store <= 1'b1;
            exe.func     <= sq_retire.func;
            exe.tag      <= sq_retire.tag;
            exe.addr     <= sq_retire.addr;
            exe.data     <= sq_retire.data;
        end else begin
            exe.is_store <= 1'b0;
            exe.func     <= lsu_func;
            exe.tag      <= i_tag;
            exe.addr     <= addr;
            exe.data     <= i_src_b;
        end
    end

    // A pending retire must already hold off the issue port
    assert property (@(posedge clk) disable iff (!n_rst) !(retire_fire && accept));

    // Queue must have room for every allocation the issue logic lets through
    assert property (@(posedge clk) disable iff (!n_rst) sq_alloc.valid |-> sq_alloc.ready);

endmodule

/* source/lsu_sq.sv */
// In-order store queue that holds stores until commit and retires committed ones in order
`timescale 1ns/1ps

module lsu_sq (
    input  logic    clk,
    input  logic    n_rst,
    input  logic    i_flush,
    input  logic    i_commit,
    lsu_req_if.dst  alloc,
    lsu_req_if.src  retire,
    output logic    o_empty
);
    import lsu_pkg::*;

    // Pointers carry one extra wrap bit to tell full from empty
    logic [SQ_PTR_WIDTH:0]   head_ptr;
    logic [SQ_PTR_WIDTH:0]   tail_ptr;
    logic [SQ_PTR_WIDTH:0]   cmt_ptr;
    logic [SQ_PTR_WIDTH:0]   cmt_next;
    logic [SQ_PTR_WIDTH:0]   count;
    logic                    full;
    logic                    alloc_fire;
    logic                    has_uncommitted;
    logic                    retire_fire;

    lsu_func_t               sq_func [SQ_DEPTH];
    logic [TAG_WIDTH-1:0]    sq_tag  [SQ_DEPTH];
    logic [ADDR_WIDTH-1:0]   sq_addr [SQ_DEPTH];
    logic [DATA_WIDTH-1:0]   sq_data [SQ_DEPTH];

    assign count       = tail_ptr - head_ptr;
    assign full        = count == (SQ_PTR_WIDTH+1)'(SQ_DEPTH);
    assign o_empty     = head_ptr == tail_ptr;
    assign alloc.ready = ~full;
    assign alloc_fire  = alloc.valid & alloc.ready;

    // A commit may land on the store being written this cycle
    assign has_uncommitted = (cmt_ptr != tail_ptr) | alloc_fire;
    assign cmt_next        = cmt_ptr + (SQ_PTR_WIDTH+1)'(i_commit & has_uncommitted);

    // Only committed entries between head and commit pointer are offered
    assign retire.valid = head_ptr != cmt_ptr;
    assign retire.func  = sq_func[head_ptr[SQ_PTR_WIDTH-1:0]];
    assign retire.tag   = sq_tag[head_ptr[SQ_PTR_WIDTH-1:0]];
    assign retire.addr  = sq_addr[head_ptr[SQ_PTR_WIDTH-1:0]];
    assign retire.data  = sq_data[head_ptr[SQ_PTR_WIDTH-1:0]];
    assign retire_fire  = retire.valid & retire.ready;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            cmt_ptr  <= '0;
        end else begin
            head_ptr <= head_ptr + (SQ_PTR_WIDTH+1)'(retire_fire);
            cmt_ptr  <= cmt_next;
            // Flush rolls the tail back to the last committed entry
            if (i_flush) begin
                tail_ptr <= cmt_next;
            end else begin
                tail_ptr <= tail_ptr + (SQ_PTR_WIDTH+1)'(alloc_fire);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            sq_func[tail_ptr[SQ_PTR_WIDTH-1:0]] <= alloc.func;
            sq_tag[tail_ptr[SQ_PTR_WIDTH-1:0]]  <= alloc.tag;
            sq_addr[tail_ptr[SQ_PTR_WIDTH-1:0]] <= alloc.addr;
            sq_data[tail_ptr[SQ_PTR_WIDTH-1:0]] <= alloc.data;
        end
    end

    // Commit pulses must match stores the issue side has already sent
    assert property (@(posedge clk) disable iff (!n_rst) i_commit |-> has_uncommitted);

    assert property (@(posedge clk) disable iff (!n_rst) alloc.valid |-> !full);

endmodule

/* source/lsu_dc.sv */
// Always-hit word memory that writes store byte lanes and returns extended load data
`timescale 1ns/1ps

module lsu_dc (
    input  logic                            clk,
    lsu_exe_if.dc                           exe,
    output logic                            o_load_valid,
    output logic [lsu_pkg::TAG_WIDTH-1:0]   o_load_tag,
    output logic [lsu_pkg::DATA_WIDTH-1:0]  o_load_data
);
    import lsu_pkg::*;

    logic [WORD_IDX_WIDTH-1:0] word_idx;
    logic [BYTE_LANES-1:0]     byte_en;
    logic [DATA_WIDTH-1:0]     wr_data;
    logic [DATA_WIDTH-1:0]     rd_word;
    logic [DATA_WIDTH-1:0]     byte_sel;
    logic [DATA_WIDTH-1:0]     half_sel;
    logic [DATA_WIDTH-1:0]     load_data;
    logic [DATA_WIDTH-1:0]     mem [MEM_WORDS];

    assign word_idx = exe.addr[WORD_IDX_WIDTH+1:2];
    assign rd_word  = mem[word_idx];

    // Sub-word offsets below the access size are dropped
    assign byte_sel = rd_word >> {exe.addr[1:0], 3'b000};
    assign half_sel = rd_word >> {exe.addr[1], 4'b0000};

    // Replicate store data across lanes and enable only the addressed ones
    always_comb begin
        case (exe.func)
            SB: begin
                byte_en = BYTE_LANES'(1) << exe.addr[1:0];
                wr_data = {BYTE_LANES{exe.data[7:0]}};
            end
            SH: begin
                byte_en = BYTE_LANES'(3) << {exe.addr[1], 1'b0};
                wr_data = {(BYTE_LANES/2){exe.data[15:0]}};
            end
            default: begin
                byte_en = '1;
                wr_data = exe.data;
            end
        endcase
    end

    always_comb begin
        case (exe.func)
            LB:      load_data = {{(DATA_WIDTH-8){byte_sel[7]}}, byte_sel[7:0]};
            LBU:     load_data = {{(DATA_WIDTH-8){1'b0}}, byte_sel[7:0]};
            LH:      load_data = {{(DATA_WIDTH-16){half_sel[15]}}, half_sel[15:0]};
            LHU:     load_data = {{(DATA_WIDTH-16){1'b0}}, half_sel[15:0]};
            default: load_data = rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (exe.valid && exe.is_store) begin
            for (int i = 0; i < BYTE_LANES; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    // Load result, one cycle behind the execute register
    always_ff @(posedge clk) begin
        o_load_valid <= exe.valid & ~exe.is_store;
        o_load_tag   <= exe.tag;
        o_load_data  <= load_data;
    end

    // Loads wait for the queue to drain, so a result never meets a store write
    assert property (@(posedge clk) (exe.valid && exe.is_store) |-> !o_load_valid);

endmodule

/* source/lsu_top.sv */
// Load/store unit top level, connects decode, store queue and data memory
`timescale 1ns/1ps

module lsu_top (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_flush,
    input  logic                            i_commit,
    input  logic                            i_valid,
    output logic                            o_ready,
    input  lsu_pkg::lsu_insn_u              i_insn,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]  i_src_a,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]  i_src_b,
    input  logic [lsu_pkg::TAG_WIDTH-1:0]   i_tag,
    output logic                            o_load_valid,
    output logic [lsu_pkg::TAG_WIDTH-1:0]   o_load_tag,
    output logic [lsu_pkg::DATA_WIDTH-1:0]  o_load_data
);

    logic sq_empty;

    lsu_req_if alloc_if ();
    lsu_req_if retire_if ();
    lsu_exe_if exe_if ();

    lsu_ad u_ad (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_flush    (i_flush),
        .i_valid    (i_valid),
        .i_insn     (i_insn),
        .i_src_a    (i_src_a),
        .i_src_b    (i_src_b),
        .i_tag      (i_tag),
        .i_sq_empty (sq_empty),
        .o_ready    (o_ready),
        .sq_alloc   (alloc_if.src),
        .sq_retire  (retire_if.dst),
        .exe        (exe_if.ad)
    );

    lsu_sq u_sq (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_commit (i_commit),
        .alloc    (alloc_if.dst),
        .retire   (retire_if.src),
        .o_empty  (sq_empty)
    );

    lsu_dc u_dc (
        .clk          (clk),
        .exe          (exe_if.dc),
        .o_load_valid (o_load_valid),
        .o_load_tag   (o_load_tag),
        .o_load_data  (o_load_data)
    );

endmodule

/* bench/lsu_tb_model.svh */
// Random source, memory model and value check for the LSU testbench, included in its top module
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

    // Galois form of x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic [31:0] lfsr_state = 32'd96;
    logic [31:0] mem_model [MEM_WORDS];

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
        end
        return r;
    endfunction

    // funct3 000 is a byte store, 001 a halfword, anything else a full word
    function automatic void model_store(input logic [2:0] f3, input logic [7:0] addr,
                                        input logic [31:0] data);
        logic [5:0] w;
        w = addr[7:2];
        case (f3)
            3'b000:  mem_model[w][addr[1:0]*8 +: 8] = data[7:0];
            3'b001:  mem_model[w][addr[1]*16 +: 16] = data[15:0];
            default: mem_model[w] = data;
        endcase
    endfunction

    function automatic logic [31:0] ref_load(input logic [2:0] f3, input logic [7:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = mem_model[addr[7:2]];
        b = w[addr[1:0]*8 +: 8];
        h = w[addr[1]*16 +: 16];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b100:  return {24'h0, b};
            3'b101:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

`endif

/* bench/lsu_tb.sv */
// Self-checking testbench for the load/store unit, top module of the simulation
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int ROUNDS       = 24;
    localparam int TOTAL_OPS    = 2 * MEM_WORDS + 6 * ROUNDS + 40;
    // A store with its commit and retire stays well under 8 cycles
    localparam int MAX_CYCLES   = RESET_CYCLES + 8 * TOTAL_OPS + 100;

    logic                  clk;
    logic                  n_rst;
    logic                  i_flush;
    logic                  i_commit;
    logic                  i_valid;
    logic                  o_ready;
    lsu_insn_u             i_insn;
    logic [DATA_WIDTH-1:0] i_src_a;
    logic [DATA_WIDTH-1:0] i_src_b;
    logic [TAG_WIDTH-1:0]  i_tag;
    logic                  o_load_valid;
    logic [TAG_WIDTH-1:0]  o_load_tag;
    logic [DATA_WIDTH-1:0] o_load_data;

    int cycles       = 0;
    int error_count  = 0;
    int test_errors  = 0;
    int test_count   = 0;
    int failed_tests = 0;

    // Op at the issue port and what the model knows about it
    logic [31:0]          op_insn    = '0;
    logic [31:0]          op_a       = '0;
    logic [31:0]          op_b       = '0;
    logic                 op_store   = 1'b0;
    logic [2:0]           op_f3      = '0;
    logic [7:0]           op_addr    = '0;
    logic [TAG_WIDTH-1:0] op_tag     = '0;
    logic                 accepted   = 1'b0;
    logic                 ready_seen = 1'b0;

    // Uncommitted stores, oldest first
    logic [2:0]           pend_f3   [$];
    logic [7:0]           pend_addr [$];
    logic [31:0]          pend_data [$];
    logic [TAG_WIDTH-1:0] exp_tag   [$];
    logic [31:0]          exp_data  [$];
    int                   exp_cycle [$];

    `include "lsu_tb_model.svh"

    lsu_top UUT (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_flush      (i_flush),
        .i_commit     (i_commit),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_insn       (i_insn),
        .i_src_a      (i_src_a),
        .i_src_b      (i_src_b),
        .i_tag        (i_tag),
        .o_load_valid (o_load_valid),
        .o_load_tag   (o_load_tag),
        .o_load_data  (o_load_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d loads still outstanding",
                     cycles, exp_tag.size());
            $display("Result: FAILED");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    // Pairs each load result with the oldest accepted load
    always @(negedge clk) begin
        int lat;
        if (n_rst && o_load_valid === 1'b1) begin
            if (exp_tag.size() == 0) begin
                $display("Load result with tag %0h arrived with no load outstanding", o_load_tag);
                error_count++;
                test_errors++;
            end else begin
                check_value("o_load_tag", o_load_tag, exp_tag.pop_front());
                check_value("o_load_data", o_load_data, exp_data.pop_front());
                lat = cycles - exp_cycle.pop_front();
                if (lat != 2) begin
                    $display("Load with tag %0h returned %0d cycles after issue, not 2",
                             o_load_tag, lat);
                    error_count++;
                    test_errors++;
                end
            end
        end
    end

    task automatic step(input logic valid, input logic flush, input logic commit);
        @(negedge clk);
        i_valid  = valid;
        i_insn   = op_insn;
        i_src_a  = op_a;
        i_src_b  = op_b;
        i_tag    = op_tag;
        i_flush  = flush;
        i_commit = commit;
        @(posedge clk);
        ready_seen = o_ready;
        accepted   = valid && o_ready;
        if (commit && pend_f3.size() > 0) begin
            model_store(pend_f3.pop_front(), pend_addr.pop_front(), pend_data.pop_front());
        end
        if (flush) begin
            pend_f3.delete();
            pend_addr.delete();
            pend_data.delete();
        end
        if (accepted && !flush) begin
            if (op_store) begin
                pend_f3.push_back(op_f3);
                pend_addr.push_back(op_addr);
                pend_data.push_back(op_b);
            end else begin
                exp_tag.push_back(op_tag);
                exp_data.push_back(ref_load(op_f3, op_addr));
                exp_cycle.push_back(cycles);
            end
            op_tag++;
        end
    endtask

    // Source A is chosen so that source A plus the immediate lands on addr
    task automatic make_op(input logic is_store, input logic [2:0] f3, input logic [7:0] addr,
                           input logic [31:0] data);
        logic [11:0] imm;
        imm      = 12'(rand_bits(12));
        op_a     = {24'h0, addr} - {{20{imm[11]}}, imm};
        op_insn  = is_store ? {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPCODE_STORE}
                            : {imm, 5'd1, f3, 5'd3, OPCODE_LOAD};
        op_b     = data;
        op_store = is_store;
        op_f3    = f3;
        op_addr  = addr;
    endtask

    task automatic issue(input logic is_store, input logic [2:0] f3, input logic [7:0] addr,
                         input logic [31:0] data);
        make_op(is_store, f3, addr, data);
        do begin
            step(1'b1, 1'b0, 1'b0);
        end while (!accepted);
    endtask

    task automatic commit_store();
        step(1'b0, 1'b0, 1'b1);
    endtask

    task automatic end_test(input string name);
        step(1'b0, 1'b0, 1'b0);
        while (exp_tag.size() > 0) begin
            @(posedge clk);
        end
        test_count++;
        if (test_errors > 0) begin
            failed_tests++;
        end
        $display("Test %0d %-11s %s, %0d errors", test_count, name,
                 test_errors == 0 ? "ok" : "failed", test_errors);
        test_errors = 0;
    endtask

    initial begin
        logic [7:0] a0;
        logic [7:0] a1;
        logic       done;
        logic       stall;
        clk      = 1'b0;
        n_rst    = 1'b0;
        i_flush  = 1'b0;
        i_commit = 1'b0;
        i_valid  = 1'b0;
        i_insn   = '0;
        i_src_a  = '0;
        i_src_b  = '0;
        i_tag    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = '0;
        end

        // Result valid settles low within two edges of reset and stays low after it
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                check_value("o_load_valid", o_load_valid, 32'h0);
            end
        end
        n_rst = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("o_load_valid", o_load_valid, 32'h0);
        end
        end_test("reset");

        for (int w = 0; w < MEM_WORDS; w++) begin
            issue(1'b1, 3'b010, 8'(w * 4), rand_bits(32));
            commit_store();
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            issue(1'b0, 3'b010, 8'(w * 4), 32'h0);
        end
        end_test("fill");

        for (int r = 0; r < ROUNDS; r++) begin
            a0 = 8'(rand_bits(8));
            a1 = 8'(rand_bits(8));
            issue(1'b1, 3'(rand_bits(1)), a0, rand_bits(32));
            commit_store();
            issue(1'b1, 3'(rand_bits(1)), a1, rand_bits(32));
            commit_store();
            issue(1'b0, 3'(rand_bits(3)), {a0[7:2], 2'(rand_bits(2))}, 32'h0);
            issue(1'b0, 3'(rand_bits(3)), {a1[7:2], 2'(rand_bits(2))}, 32'h0);
        end
        end_test("sub-word");

        issue(1'b1, 3'b010, 8'h28, rand_bits(32));
        commit_store();
        issue(1'b1, 3'b010, 8'h50, rand_bits(32));
        issue(1'b1, 3'b000, 8'h79, rand_bits(32));
        // Flush while the last store is still being allocated, then flush
        // again in the cycle that accepts the next store
        make_op(1'b1, 3'b010, 8'h90, rand_bits(32));
        do begin
            step(1'b1, 1'b1, 1'b0);
        end while (!accepted);
        issue(1'b0, 3'b010, 8'h28, 32'h0);
        issue(1'b0, 3'b010, 8'h50, 32'h0);
        issue(1'b0, 3'b010, 8'h78, 32'h0);
        issue(1'b0, 3'b010, 8'h90, 32'h0);
        end_test("flush");

        issue(1'b1, 3'b000, 8'hc0, rand_bits(32));
        issue(1'b1, 3'b000, 8'hc1, rand_bits(32));
        issue(1'b1, 3'b000, 8'hc3, rand_bits(32));
        make_op(1'b0, 3'b010, 8'hc0, 32'h0);
        // Only the uncommitted stores in the queue hold the load back here
        repeat (3) begin
            step(1'b1, 1'b0, 1'b0);
            check_value("o_ready", ready_seen, 32'h0);
        end
        done = 1'b0;
        while (!done) begin
            stall = pend_f3.size() > 0;
            step(1'b1, 1'b0, stall);
            if (stall) begin
                check_value("o_ready", ready_seen, 32'h0);
            end
            done = accepted;
        end
        end_test("load stall");

        for (int i = 0; i < SQ_DEPTH; i++) begin
            issue(1'b1, 3'b010, 8'(8'he0 + 4 * i), rand_bits(32));
        end
        make_op(1'b1, 3'b010, 8'hf0, rand_bits(32));
        repeat (3) begin
            step(1'b1, 1'b0, 1'b0);
            check_value("o_ready", ready_seen, 32'h0);
        end
        done = 1'b0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            step(!done, 1'b0, 1'b1);
            done = done | accepted;
        end
        while (!done) begin
            step(1'b1, 1'b0, 1'b0);
            done = accepted;
        end
        commit_store();
        for (int i = 0; i <= SQ_DEPTH; i++) begin
            issue(1'b0, 3'b010, 8'(8'he0 + 4 * i), 32'h0);
        end
        end_test("queue full");

        $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+bench
source/lsu_pkg.sv
source/lsu_ifs.sv
source/lsu_ad.sv
source/lsu_sq.sv
source/lsu_dc.sv
source/lsu_top.sv
bench/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - target: any(rtl, test)
    files:
      - source/lsu_pkg.sv
      - source/lsu_ifs.sv
      - source/lsu_ad.sv
      - source/lsu_sq.sv
      - source/lsu_dc.sv
      - source/lsu_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/lsu_tb.sv
